/* verilog/nxthp_defines.svh */
// width and count macros of the next-hop store, included by every file that sizes a port or type
`ifndef NXTHP_DEFINES_SVH
`define NXTHP_DEFINES_SVH

// full request address as seen by the requester
`define NXTHP_ADDR_W 10

// the bank is chosen by the top address bits
`define NXTHP_BANK_W 2
`define NXTHP_NUM_BANKS 4

// offset inside one bank, 256 words deep
`define NXTHP_OFS_W 8

// 14 pointer bits plus one parity bit that the store treats as plain data
`define NXTHP_PAYLOAD_W 15

// five Hamming check bits and one overall parity bit on top
`define NXTHP_ECC_W 6
`define NXTHP_WORD_W 21

`endif

/* verilog/nxthp_pkg.sv */
// shared command and word types of the next-hop store, imported by the RTL and the testbench
`default_nettype none

`include "nxthp_defines.svh"

package nxthp_pkg;

  // command carried from the requester down to the bank pipe
  typedef enum logic [1:0] {
    NXTHP_NOP       = 2'd0,
    NXTHP_READ      = 2'd1,
    NXTHP_WRITE     = 2'd2,
    NXTHP_WRITE_RAW = 2'd3
  } nxthp_cmd_t;

  // a normal write only brings the payload and the upper bits are don't care
  typedef struct packed {
    logic [`NXTHP_ECC_W-1:0]     pad;
    logic [`NXTHP_PAYLOAD_W-1:0] payload;
  } nxthp_pipe_view_t;

  // what the array holds, check bits above the payload
  typedef struct packed {
    logic [`NXTHP_ECC_W-1:0]     ecc;
    logic [`NXTHP_PAYLOAD_W-1:0] payload;
  } nxthp_mem_view_t;

  // one 21 bit word, decoded per command as pipe data or as a full memory word
  typedef union packed {
    nxthp_pipe_view_t pipe;
    nxthp_mem_view_t  mem;
  } nxthp_word_u;

endpackage

`default_nettype wire

/* verilog/nxthp_secded.sv */
// SECDED codec of one bank, generating check bits for writes and correcting words read back
`timescale 1ns/1ps
`default_nettype none

`include "nxthp_defines.svh"

module nxthp_secded (
  input  logic [`NXTHP_PAYLOAD_W-1:0] gen_payload,
  output logic [`NXTHP_ECC_W-1:0]     gen_ecc,
  input  logic                        chk_v,
  input  nxthp_pkg::nxthp_word_u      chk_word,
  output logic [`NXTHP_PAYLOAD_W-1:0] chk_payload,
  output logic                        error_sb,
  output logic                        error_mb
);

  // codeword position of each payload bit, the non power of two slots from 1 to 20
  localparam logic [`NXTHP_ECC_W-2:0] DATA_POS [`NXTHP_PAYLOAD_W] = '{
    5'd3, 5'd5, 5'd6, 5'd7, 5'd9, 5'd10, 5'd11, 5'd12,
    5'd13, 5'd14, 5'd15, 5'd17, 5'd18, 5'd19, 5'd20
  };

  logic [`NXTHP_ECC_W-2:0]     gen_ham;
  logic [`NXTHP_ECC_W-2:0]     syndrome;
  logic [`NXTHP_PAYLOAD_W-1:0] stored_payload;
  logic                        parity_err;

  // each set payload bit folds its position into the check bits
  // so check bit i ends up as the xor of all positions with bit i set
  function automatic logic [`NXTHP_ECC_W-2:0] hamming(input logic [`NXTHP_PAYLOAD_W-1:0] d);
    logic [`NXTHP_ECC_W-2:0] c;
    c = '0;
    for (int k = 0; k < `NXTHP_PAYLOAD_W; k++) begin
      if (d[k]) begin
        c = c ^ DATA_POS[k];
      end
    end
    return c;
  endfunction

  // top check bit makes the whole stored word even
  always_comb begin
    gen_ham = hamming(gen_payload);
    gen_ecc = {(^gen_payload) ^ (^gen_ham), gen_ham};
  end

  always_comb begin
    stored_payload = chk_word.mem.payload;
    syndrome       = hamming(stored_payload) ^ chk_word.mem.ecc[`NXTHP_ECC_W-2:0];
    // a clean word has even parity over all 21 bits
    parity_err     = ^chk_word.mem;

    // an odd error count with a syndrome pointing at a payload slot flips that bit
    // and a syndrome pointing at a check slot leaves the payload alone
    chk_payload = stored_payload;
    for (int k = 0; k < `NXTHP_PAYLOAD_W; k++) begin
      if (parity_err && (syndrome == DATA_POS[k])) begin
        chk_payload[k] = ~stored_payload[k];
      end
    end

    // even error count with a nonzero syndrome cannot be located
    error_sb = chk_v && parity_err;
    error_mb = chk_v && (syndrome != '0) && !parity_err;
  end

  // the decode must classify a word as at most one kind of error
  always_comb begin
    a_flags_onehot : assert final (!(error_sb && error_mb))
      else $error("secded flags single and double error on the same word");
  end

endmodule

`default_nettype wire

/* verilog/nxthp_rw_pipe.sv */
// four stage read/write pipe of one bank, driving its memory port and stalling as a whole on hold
`timescale 1ns/1ps
`default_nettype none

`include "nxthp_defines.svh"

module nxthp_rw_pipe (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        hold,
  input  logic                        p0_v_nxt,
  input  nxthp_pkg::nxthp_cmd_t       p0_cmd_nxt,
  input  logic [`NXTHP_OFS_W-1:0]     p0_ofs_nxt,
  input  nxthp_pkg::nxthp_word_u      p0_wdata_nxt,
  output logic                        p1_v,
  output nxthp_pkg::nxthp_cmd_t       p1_cmd,
  output logic [`NXTHP_OFS_W-1:0]     p1_ofs,
  output nxthp_pkg::nxthp_word_u      p1_wdata,
  output logic                        p2_v,
  output nxthp_pkg::nxthp_cmd_t       p2_cmd,
  output logic [`NXTHP_OFS_W-1:0]     p2_ofs,
  input  logic                        p3_v_nxt,
  input  logic [`NXTHP_PAYLOAD_W+1:0] p3_data_nxt,
  output logic                        p3_v,
  output logic [`NXTHP_OFS_W-1:0]     p3_ofs,
  output logic [`NXTHP_PAYLOAD_W+1:0] p3_data,
  output logic                        mem_write,
  output logic                        mem_read,
  output logic [`NXTHP_OFS_W-1:0]     mem_addr
);

  import nxthp_pkg::*;

  logic                    p0_v;
  nxthp_cmd_t              p0_cmd;
  logic [`NXTHP_OFS_W-1:0] p0_ofs;
  nxthp_word_u             p0_wdata;

  // valid bits of the four stages, all empty after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      p0_v <= 1'b0;
      p1_v <= 1'b0;
      p2_v <= 1'b0;
      p3_v <= 1'b0;
    end else if (!hold) begin
      p0_v <= p0_v_nxt;
      p1_v <= p0_v;
      p2_v <= p1_v;
      // p3 only keeps reads, writes have already retired at p1
      p3_v <= p3_v_nxt;
    end
  end

  // command, offset and data shift along with their valid bits
  always_ff @(posedge clk) begin
    if (!hold) begin
      p0_cmd   <= p0_cmd_nxt;
      p0_ofs   <= p0_ofs_nxt;
      p0_wdata <= p0_wdata_nxt;
      p1_cmd   <= p0_cmd;
      p1_ofs   <= p0_ofs;
      p1_wdata <= p0_wdata;
      p2_cmd   <= p1_cmd;
      p2_ofs   <= p1_ofs;
      p3_ofs   <= p2_ofs;
      // corrected payload with both error flags packed on top
      p3_data  <= p3_data_nxt;
    end
  end

  // the memory port acts at p1 and is blocked while the pipe is frozen
  // otherwise a held read would refetch and a held write would repeat
  always_comb begin
    mem_read  = p1_v && !hold && (p1_cmd == NXTHP_READ);
    mem_write = p1_v && !hold && ((p1_cmd == NXTHP_WRITE) || (p1_cmd == NXTHP_WRITE_RAW));
    mem_addr  = p1_ofs;
  end

  // a single p1 stage can never read and write the array in one cycle
  a_port_excl : assert property (@(posedge clk) disable iff (rst)
    !(mem_read && mem_write))
    else $error("memory port read and write asserted together");

endmodule

`default_nettype wire

/* verilog/nxthp_bank.sv */
// one bank of the next-hop store with its pipe, SECDED codec and 256 word array
`timescale 1ns/1ps
`default_nettype none

`include "nxthp_defines.svh"

module nxthp_bank (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    p0_v,
  input  nxthp_pkg::nxthp_cmd_t   p0_cmd,
  input  logic [`NXTHP_OFS_W-1:0] p0_ofs,
  input  nxthp_pkg::nxthp_word_u  p0_wdata,
  input  logic                    hold,
  output logic                    p3_v,
  output logic [`NXTHP_OFS_W-1:0] p3_ofs,
  output nxthp_pkg::nxthp_word_u  p3_data,
  output logic                    p3_error_sb,
  output logic                    p3_error_mb
);

  import nxthp_pkg::*;

  nxthp_cmd_t                  p1_cmd;
  nxthp_word_u                 p1_wdata;
  logic                        p2_v;
  nxthp_cmd_t                  p2_cmd;
  logic                        p3_v_nxt;
  logic [`NXTHP_PAYLOAD_W+1:0] p3_data_nxt;
  logic [`NXTHP_PAYLOAD_W+1:0] p3_bundle;
  logic                        mem_write;
  logic                        mem_read;
  logic [`NXTHP_OFS_W-1:0]     mem_addr;
  logic [`NXTHP_ECC_W-1:0]     gen_ecc;
  logic [`NXTHP_PAYLOAD_W-1:0] chk_payload;
  logic                        chk_sb;
  logic                        chk_mb;
  nxthp_word_u                 wr_word;
  nxthp_word_u                 rd_word;
  nxthp_word_u                 mem_array [1 << `NXTHP_OFS_W];

  nxthp_rw_pipe u_pipe (
    .clk          (clk),
    .rst          (rst),
    .hold         (hold),
    .p0_v_nxt     (p0_v),
    .p0_cmd_nxt   (p0_cmd),
    .p0_ofs_nxt   (p0_ofs),
    .p0_wdata_nxt (p0_wdata),
    .p1_v         (),
    .p1_cmd       (p1_cmd),
    .p1_ofs       (),
    .p1_wdata     (p1_wdata),
    .p2_v         (p2_v),
    .p2_cmd       (p2_cmd),
    .p2_ofs       (),
    .p3_v_nxt     (p3_v_nxt),
    .p3_data_nxt  (p3_data_nxt),
    .p3_v         (p3_v),
    .p3_ofs       (p3_ofs),
    .p3_data      (p3_bundle),
    .mem_write    (mem_write),
    .mem_read     (mem_read),
    .mem_addr     (mem_addr)
  );

  // write side encodes the pipe payload, read side checks the word fetched at p1
  nxthp_secded u_secded (
    .gen_payload (p1_wdata.pipe.payload),
    .gen_ecc     (gen_ecc),
    .chk_v       (p3_v_nxt),
    .chk_word    (rd_word),
    .chk_payload (chk_payload),
    .error_sb    (chk_sb),
    .error_mb    (chk_mb)
  );

  // raw writes land as given so a test can plant bad check bits
  always_comb begin
    if (p1_cmd == NXTHP_WRITE_RAW) begin
      wr_word = p1_wdata;
    end else begin
      wr_word.mem.ecc     = gen_ecc;
      wr_word.mem.payload = p1_wdata.pipe.payload;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem_array[mem_addr] <= wr_word;
    end
  end

  // read data is registered and lines up with the p2 stage
  always_ff @(posedge clk) begin
    if (mem_read) begin
      rd_word <= mem_array[mem_addr];
    end
  end

  // only reads go on to p3 and carry their corrected payload and flags
  assign p3_v_nxt    = p2_v && (p2_cmd == NXTHP_READ);
  assign p3_data_nxt = {chk_mb, chk_sb, chk_payload};

  always_comb begin
    p3_data.pipe.pad     = '0;
    p3_data.pipe.payload = p3_bundle[`NXTHP_PAYLOAD_W-1:0];
    p3_error_sb          = p3_bundle[`NXTHP_PAYLOAD_W];
    p3_error_mb          = p3_bundle[`NXTHP_PAYLOAD_W+1];
  end

endmodule

`default_nettype wire

/* verilog/nxthp_req_dispatch.sv */
// four-phase request receiver that issues each command to the bank selected by its address
`timescale 1ns/1ps
`default_nettype none

`include "nxthp_defines.svh"

module nxthp_req_dispatch (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req,
  input  nxthp_pkg::nxthp_cmd_t       cmd,
  input  logic [`NXTHP_ADDR_W-1:0]    addr,
  input  nxthp_pkg::nxthp_word_u      wdata,
  output logic                        ack,
  input  logic [`NXTHP_NUM_BANKS-1:0] bank_hold,
  output logic [`NXTHP_NUM_BANKS-1:0] p0_v,
  output nxthp_pkg::nxthp_cmd_t       p0_cmd,
  output logic [`NXTHP_OFS_W-1:0]     p0_ofs,
  output nxthp_pkg::nxthp_word_u      p0_wdata
);

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUED, ST_WAIT_DROP} state_t;

  state_t                   state;
  logic [`NXTHP_BANK_W-1:0] bank_sel;

  // the bank comes from the top address bits and the rest is the bank offset
  assign bank_sel = addr[`NXTHP_ADDR_W-1 -: `NXTHP_BANK_W];
  assign p0_ofs   = addr[`NXTHP_OFS_W-1:0];
  assign p0_cmd   = cmd;
  assign p0_wdata = wdata;

  // the command goes out once while idle, and a held bank simply delays it
  always_comb begin
    p0_v = '0;
    if ((state == ST_IDLE) && req && !bank_hold[bank_sel]) begin
      p0_v[bank_sel] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (|p0_v) state <= ST_ISSUED;
        // requester may drop req as soon as it sees ack
        ST_ISSUED: state <= req ? ST_WAIT_DROP : ST_IDLE;
        ST_WAIT_DROP: if (!req) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ack is up from the issue until req has been seen low
  assign ack = (state != ST_IDLE);

  // a stalled pipe drops p0, so a command sent into a held bank would be lost
  a_no_issue_held : assert property (@(posedge clk) disable iff (rst)
    (p0_v & bank_hold) == '0)
    else $error("command issued to a bank that is held");

endmodule

`default_nettype wire

/* verilog/nxthp_rsp_collect.sv */
// fixed-priority collector of bank read completions that sends each over a four-phase response
`timescale 1ns/1ps
`default_nettype none

`include "nxthp_defines.svh"

module nxthp_rsp_collect (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`NXTHP_NUM_BANKS-1:0] bank_p3_v,
  input  logic [`NXTHP_OFS_W-1:0]     bank_p3_ofs [`NXTHP_NUM_BANKS],
  input  nxthp_pkg::nxthp_word_u      bank_p3_data [`NXTHP_NUM_BANKS],
  input  logic [`NXTHP_NUM_BANKS-1:0] bank_p3_error_sb,
  input  logic [`NXTHP_NUM_BANKS-1:0] bank_p3_error_mb,
  output logic [`NXTHP_NUM_BANKS-1:0] bank_hold,
  output logic                        rsp_req,
  input  logic                        rsp_ack,
  output logic [`NXTHP_ADDR_W-1:0]    rsp_addr,
  output nxthp_pkg::nxthp_word_u      rsp_data,
  output logic                        rsp_error_sb,
  output logic                        rsp_error_mb
);

  typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_DROP} state_t;

  state_t                   state;
  logic [`NXTHP_BANK_W-1:0] sel;
  logic                     take;

  // lowest numbered bank with a finished read wins
  always_comb begin
    sel = '0;
    for (int i = `NXTHP_NUM_BANKS - 1; i >= 0; i--) begin
      if (bank_p3_v[i]) begin
        sel = i[`NXTHP_BANK_W-1:0];
      end
    end
  end

  assign take = (state == ST_IDLE) && (|bank_p3_v);

  // every waiting completion that is not taken keeps its bank frozen
  always_comb begin
    for (int i = 0; i < `NXTHP_NUM_BANKS; i++) begin
      bank_hold[i] = bank_p3_v[i] && !(take && (sel == i[`NXTHP_BANK_W-1:0]));
    end
  end

  // the bank index goes back on top of the offset to rebuild the request address
  always_ff @(posedge clk) begin
    if (take) begin
      rsp_addr     <= {sel, bank_p3_ofs[sel]};
      rsp_data     <= bank_p3_data[sel];
      rsp_error_sb <= bank_p3_error_sb[sel];
      rsp_error_mb <= bank_p3_error_mb[sel];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (take) state <= ST_SEND;
        ST_SEND: if (rsp_ack) state <= ST_DROP;
        // nothing new is taken until the receiver has let go of rsp_ack
        ST_DROP: if (!rsp_ack) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign rsp_req = (state == ST_SEND);

  // the receiver may sample the fields any time during the request phase
  a_rsp_stable : assert property (@(posedge clk) disable iff (rst)
    rsp_req |=> !rsp_req || $stable({rsp_addr, rsp_data, rsp_error_sb, rsp_error_mb}))
    else $error("response fields changed while rsp_req was high");

endmodule

`default_nettype wire

/* verilog/nxthp_top.sv */
// top of the banked next-hop store, joining the dispatcher, four banks and the response collector
`timescale 1ns/1ps
`default_nettype none

`include "nxthp_defines.svh"

module nxthp_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req,
  input  nxthp_pkg::nxthp_cmd_t    cmd,
  input  logic [`NXTHP_ADDR_W-1:0] addr,
  input  nxthp_pkg::nxthp_word_u   wdata,
  output logic                     ack,
  output logic                     rsp_req,
  input  logic                     rsp_ack,
  output logic [`NXTHP_ADDR_W-1:0] rsp_addr,
  output nxthp_pkg::nxthp_word_u   rsp_data,
  output logic                     rsp_error_sb,
  output logic                     rsp_error_mb
);

  import nxthp_pkg::*;

  logic [`NXTHP_NUM_BANKS-1:0] bank_hold;
  logic [`NXTHP_NUM_BANKS-1:0] p0_v;
  nxthp_cmd_t                  p0_cmd;
  logic [`NXTHP_OFS_W-1:0]     p0_ofs;
  nxthp_word_u                 p0_wdata;
  logic [`NXTHP_NUM_BANKS-1:0] bank_p3_v;
  logic [`NXTHP_OFS_W-1:0]     bank_p3_ofs [`NXTHP_NUM_BANKS];
  nxthp_word_u                 bank_p3_data [`NXTHP_NUM_BANKS];
  logic [`NXTHP_NUM_BANKS-1:0] bank_p3_error_sb;
  logic [`NXTHP_NUM_BANKS-1:0] bank_p3_error_mb;

  nxthp_req_dispatch u_dispatch (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .cmd       (cmd),
    .addr      (addr),
    .wdata     (wdata),
    .ack       (ack),
    .bank_hold (bank_hold),
    .p0_v      (p0_v),
    .p0_cmd    (p0_cmd),
    .p0_ofs    (p0_ofs),
    .p0_wdata  (p0_wdata)
  );

  // all banks see the same command and only the one with p0_v set takes it
  for (genvar i = 0; i < `NXTHP_NUM_BANKS; i++) begin : g_bank
    nxthp_bank u_bank (
      .clk         (clk),
      .rst         (rst),
      .p0_v        (p0_v[i]),
      .p0_cmd      (p0_cmd),
      .p0_ofs      (p0_ofs),
      .p0_wdata    (p0_wdata),
      .hold        (bank_hold[i]),
      .p3_v        (bank_p3_v[i]),
      .p3_ofs      (bank_p3_ofs[i]),
      .p3_data     (bank_p3_data[i]),
      .p3_error_sb (bank_p3_error_sb[i]),
      .p3_error_mb (bank_p3_error_mb[i])
    );
  end

  nxthp_rsp_collect u_collect (
    .clk              (clk),
    .rst              (rst),
    .bank_p3_v        (bank_p3_v),
    .bank_p3_ofs      (bank_p3_ofs),
    .bank_p3_data     (bank_p3_data),
    .bank_p3_error_sb (bank_p3_error_sb),
    .bank_p3_error_mb (bank_p3_error_mb),
    .bank_hold        (bank_hold),
    .rsp_req          (rsp_req),
    .rsp_ack          (rsp_ack),
    .rsp_addr         (rsp_addr),
    .rsp_data         (rsp_data),
    .rsp_error_sb     (rsp_error_sb),
    .rsp_error_mb     (rsp_error_mb)
  );

endmodule

`default_nettype wire

/* testbench/nxthp_tb.sv */
// testbench of the next-hop store, drives requests into nxthp_top and checks every read response
`timescale 1ns/1ps
`default_nettype none

`include "nxthp_defines.svh"

module nxthp_tb;

  import nxthp_pkg::*;

  // 40 operations are issued in total, each gets 40 cycles of budget
  localparam int NUM_OPS = 40;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40;
  localparam int DEPTH = 1 << `NXTHP_ADDR_W;

  logic                        clk;
  logic                        rst;
  logic                        req;
  nxthp_cmd_t                  cmd;
  logic [`NXTHP_ADDR_W-1:0]    addr;
  nxthp_word_u                 wdata;
  logic                        ack;
  logic                        rsp_req;
  logic                        rsp_ack;
  logic [`NXTHP_ADDR_W-1:0]    rsp_addr;
  nxthp_word_u                 rsp_data;
  logic                        rsp_error_sb;
  logic                        rsp_error_mb;

  // what a read of each address has to return
  logic [`NXTHP_PAYLOAD_W-1:0] exp_payload [DEPTH];
  logic                        exp_sb [DEPTH];
  logic                        exp_mb [DEPTH];
  int                          pending [DEPTH];
  int                          outstanding;
  int                          errors;
  int                          cycle_count;
  logic [31:0]                 seed;
  string                       test_name;

  nxthp_top uut (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .cmd          (cmd),
    .addr         (addr),
    .wdata        (wdata),
    .ack          (ack),
    .rsp_req      (rsp_req),
    .rsp_ack      (rsp_ack),
    .rsp_addr     (rsp_addr),
    .rsp_data     (rsp_data),
    .rsp_error_sb (rsp_error_sb),
    .rsp_error_mb (rsp_error_mb)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // check bits built straight from the codeword layout, payload in the non power of two slots
  function automatic logic [`NXTHP_ECC_W-1:0] ecc_of(input logic [`NXTHP_PAYLOAD_W-1:0] p);
    logic [`NXTHP_WORD_W-1:0] cw;
    logic [`NXTHP_ECC_W-1:0]  ecc;
    int                       k;
    cw = '0;
    ecc = '0;
    k = 0;
    for (int pos = 1; pos < `NXTHP_WORD_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        cw[pos] = p[k];
        k++;
      end
    end
    for (int i = 0; i < `NXTHP_ECC_W - 1; i++) begin
      for (int pos = 1; pos < `NXTHP_WORD_W; pos++) begin
        if (pos[i]) ecc[i] = ecc[i] ^ cw[pos];
      end
    end
    ecc[`NXTHP_ECC_W-1] = (^p) ^ (^ecc[`NXTHP_ECC_W-2:0]);
    return ecc;
  endfunction

  function automatic nxthp_word_u encode(input logic [`NXTHP_PAYLOAD_W-1:0] p);
    nxthp_word_u w;
    w.mem.ecc = ecc_of(p);
    w.mem.payload = p;
    return w;
  endfunction

  // one full four-phase request, entered and left on a falling edge
  task automatic send_cmd(input nxthp_cmd_t c, input logic [`NXTHP_ADDR_W-1:0] a,
                          input nxthp_word_u w);
    cmd = c;
    addr = a;
    wdata = w;
    req = 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    // odd addresses keep req up for one more cycle and let ack be seen together with req
    if (a[0]) @(negedge clk);
    req = 1'b0;
    @(negedge clk);
    while (ack) @(negedge clk);
    cmd = NXTHP_NOP;
  endtask

  task automatic write_payload(input logic [`NXTHP_ADDR_W-1:0] a,
                               input logic [`NXTHP_PAYLOAD_W-1:0] p);
    nxthp_word_u w;
    // the upper bits of a normal write are garbage on purpose
    w.pipe.pad = 6'h2a;
    w.pipe.payload = p;
    exp_payload[a] = p;
    exp_sb[a] = 1'b0;
    exp_mb[a] = 1'b0;
    send_cmd(NXTHP_WRITE, a, w);
  endtask

  task automatic write_raw(input logic [`NXTHP_ADDR_W-1:0] a, input nxthp_word_u w,
                           input logic [`NXTHP_PAYLOAD_W-1:0] p, input logic sb,
                           input logic mb);
    exp_payload[a] = p;
    exp_sb[a] = sb;
    exp_mb[a] = mb;
    send_cmd(NXTHP_WRITE_RAW, a, w);
  endtask

  task automatic read_addr(input logic [`NXTHP_ADDR_W-1:0] a);
    pending[a]++;
    outstanding++;
    send_cmd(NXTHP_READ, a, '0);
  endtask

  task automatic wait_drain();
    while (outstanding != 0) @(negedge clk);
  endtask

  // response receiver with a random 0 to 3 cycle delay before rsp_ack
  initial begin : rsp_receiver
    logic [31:0] r;
    forever begin
      @(negedge clk);
      if (rsp_req) begin
        r = $random(seed);
        repeat (r[1:0]) @(negedge clk);
        rsp_ack = 1'b1;
        @(negedge clk);
        while (rsp_req) @(negedge clk);
        rsp_ack = 1'b0;
        pending[rsp_addr]--;
        outstanding--;
      end
    end
  end

  a_rsp_payload : assert property (@(posedge clk) disable iff (rst)
    $rose(rsp_req) |-> rsp_data.pipe.payload == exp_payload[rsp_addr])
    else begin
      errors++;
      $display("CHECK FAILED %s payload at %h expected %h actual %h", test_name,
               rsp_addr, exp_payload[rsp_addr], rsp_data.pipe.payload);
    end

  a_rsp_sb : assert property (@(posedge clk) disable iff (rst)
    $rose(rsp_req) |-> rsp_error_sb == exp_sb[rsp_addr])
    else begin
      errors++;
      $display("CHECK FAILED %s error_sb at %h expected %b actual %b", test_name,
               rsp_addr, exp_sb[rsp_addr], rsp_error_sb);
    end

  a_rsp_mb : assert property (@(posedge clk) disable iff (rst)
    $rose(rsp_req) |-> rsp_error_mb == exp_mb[rsp_addr])
    else begin
      errors++;
      $display("CHECK FAILED %s error_mb at %h expected %b actual %b", test_name,
               rsp_addr, exp_mb[rsp_addr], rsp_error_mb);
    end

  // a response for an address with no read in flight is a duplicate or a stray
  a_rsp_expected : assert property (@(posedge clk) disable iff (rst)
    $rose(rsp_req) |-> pending[rsp_addr] > 0)
    else begin
      errors++;
      $display("%s: response for address %h arrived with no read outstanding",
               test_name, rsp_addr);
    end

  a_ack_hold : assert property (@(posedge clk) disable iff (rst) req && ack |=> ack)
    else begin
      errors++;
      $display("%s: ack dropped while req was still high", test_name);
    end

  a_rsp_req_hold : assert property (@(posedge clk) disable iff (rst)
    rsp_req && !rsp_ack |=> rsp_req)
    else begin
      errors++;
      $display("%s: rsp_req dropped before rsp_ack was raised", test_name);
    end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0]              r;
    logic [`NXTHP_ADDR_W-1:0] burst_addr [8];
    nxthp_word_u              w;
    rst = 1'b1;
    req = 1'b0;
    cmd = NXTHP_NOP;
    addr = '0;
    wdata = '0;
    rsp_ack = 1'b0;
    seed = 32'h988b_eaf9;
    errors = 0;
    outstanding = 0;
    test_name = "reset";
    for (int i = 0; i < DEPTH; i++) pending[i] = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    test_name = "write_read";
    write_payload(10'h005, 15'h1234);
    read_addr(10'h005);
    wait_drain();

    // same offset in every bank, the response address must carry the bank back
    test_name = "bank_steer";
    for (int b = 0; b < `NXTHP_NUM_BANKS; b++) begin
      write_payload({b[1:0], 8'h3c}, 15'h1111 * (b + 1));
    end
    for (int b = 0; b < `NXTHP_NUM_BANKS; b++) read_addr({b[1:0], 8'h3c});
    wait_drain();

    test_name = "burst_reads";
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      burst_addr[i] = {i[1:0], r[7:0]};
      write_payload(burst_addr[i], r[22:8]);
    end
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      read_addr(burst_addr[r[2:0]]);
    end
    wait_drain();

    // payload bit 6 sits in codeword slot 11 and gets corrected
    test_name = "single_payload";
    w = encode(15'h2b5d);
    w.mem.payload[6] = ~w.mem.payload[6];
    write_raw(10'h1a7, w, 15'h2b5d, 1'b1, 1'b0);
    read_addr(10'h1a7);
    wait_drain();

    test_name = "single_check";
    w = encode(15'h0f3c);
    w.mem.ecc[2] = ~w.mem.ecc[2];
    write_raw(10'h2c1, w, 15'h0f3c, 1'b1, 1'b0);
    read_addr(10'h2c1);
    wait_drain();

    // two flips leave parity even, so the stored payload comes back as is
    test_name = "double_payload";
    w = encode(15'h5a0f);
    w.mem.payload[3] = ~w.mem.payload[3];
    w.mem.payload[11] = ~w.mem.payload[11];
    write_raw(10'h390, w, w.mem.payload, 1'b0, 1'b1);
    read_addr(10'h390);
    wait_drain();

    repeat (4) @(negedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/nxthp_pkg.sv
verilog/nxthp_secded.sv
verilog/nxthp_rw_pipe.sv
verilog/nxthp_bank.sv
verilog/nxthp_req_dispatch.sv
verilog/nxthp_rsp_collect.sv
verilog/nxthp_top.sv
testbench/nxthp_tb.sv

/* Bender.yml */
package:
  name: nxthp

export_include_dirs:
  - verilog

sources:
  # package first, then the RTL bottom up
  - files:
      - verilog/nxthp_pkg.sv
      - verilog/nxthp_secded.sv
      - verilog/nxthp_rw_pipe.sv
      - verilog/nxthp_bank.sv
      - verilog/nxthp_req_dispatch.sv
      - verilog/nxthp_rsp_collect.sv
      - verilog/nxthp_top.sv
  - target: test
    files:
      - testbench/nxthp_tb.sv
